//--- all.f
wb_pkg.sv
commit_if.sv
stage_reg.sv
pipe_ctrl.sv
mem_stage.sv
arch_regs.sv
cp0_regs.sv
wb_top.sv
tb_wb.sv

//--- arch_regs.sv
`timescale 1ns/100ps
`default_nettype none

module arch_regs (
	input logic clk,
	input logic reset,
	commit_if.regs c,
	input logic [wb_pkg::reg_addr_w-1:0] raddr1,
	input logic [wb_pkg::reg_addr_w-1:0] raddr2,
	output logic [wb_pkg::data_w-1:0] rdata1,
	output logic [wb_pkg::data_w-1:0] rdata2,
	output logic [wb_pkg::data_w-1:0] hi,
	output logic [wb_pkg::data_w-1:0] lo,
	commit_if.regs pend
);

	logic [wb_pkg::data_w-1:0] gpr [32];
	logic [wb_pkg::data_w-1:0] hi_r;
	logic [wb_pkg::data_w-1:0] lo_r;

	function automatic logic [wb_pkg::data_w-1:0] read_gpr(
		input logic [wb_pkg::reg_addr_w-1:0] a
	);
		if (a == '0)
			return '0;
		else if (pend.wreg && pend.waddr == a)
			return pend.wdata; // value about to commit
		else
			return gpr[a];
	endfunction

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				gpr[i] <= '0;
			hi_r <= '0;
			lo_r <= '0;
		end
		else
		begin
			if (c.wreg && c.waddr != '0)
				gpr[c.waddr] <= c.wdata;
			if (c.whilo)
			begin
				hi_r <= c.hi;
				lo_r <= c.lo;
			end
		end
	end

	always_comb
	begin
		rdata1 = read_gpr(raddr1);
		rdata2 = read_gpr(raddr2);
	end

	assign hi = pend.whilo ? pend.hi : hi_r;
	assign lo = pend.whilo ? pend.lo : lo_r;

endmodule

`default_nettype wire

//--- commit_if.sv
`timescale 1ns/100ps
`default_nettype none

interface commit_if;

	logic [wb_pkg::data_w-1:0] pc;
	logic wreg;
	logic [wb_pkg::reg_addr_w-1:0] waddr;
	logic [wb_pkg::data_w-1:0] wdata;
	logic whilo;
	logic [wb_pkg::data_w-1:0] hi;
	logic [wb_pkg::data_w-1:0] lo;
	logic cp0_we;
	logic [wb_pkg::reg_addr_w-1:0] cp0_addr;
	logic [wb_pkg::data_w-1:0] cp0_wdata;

	modport src (
		output pc, wreg, waddr, wdata, whilo, hi, lo, cp0_we, cp0_addr, cp0_wdata
	);

	modport regs (
		input wreg, waddr, wdata, whilo, hi, lo
	);

	modport cp0 (
		input cp0_we, cp0_addr, cp0_wdata
	);

endinterface

`default_nettype wire

//--- cp0_regs.sv
`timescale 1ns/100ps
`default_nettype none

module cp0_regs (
	input logic clk,
	input logic reset,
	input logic take_exc,
	commit_if.cp0 c,
	input logic [wb_pkg::data_w-1:0] exc_epc,
	input logic [wb_pkg::reg_addr_w-1:0] cp0_raddr,
	output logic [wb_pkg::data_w-1:0] cp0_rdata,
	output logic int_pending
);

	logic [wb_pkg::data_w-1:0] count;
	logic [wb_pkg::data_w-1:0] compare;
	logic [wb_pkg::data_w-1:0] status;
	logic [wb_pkg::data_w-1:0] cause;
	logic [wb_pkg::data_w-1:0] epc;
	logic [wb_pkg::data_w-1:0] status_new;
	logic wr_count;
	logic wr_compare;
	logic wr_status;
	logic wr_epc;

	assign wr_count = c.cp0_we && c.cp0_addr == wb_pkg::cp0_count;
	assign wr_compare = c.cp0_we && c.cp0_addr == wb_pkg::cp0_compare;
	assign wr_status = c.cp0_we && c.cp0_addr == wb_pkg::cp0_status;
	assign wr_epc = c.cp0_we && c.cp0_addr == wb_pkg::cp0_epc;

	// only ie and exl are implemented
	always_comb
	begin
		status_new = '0;
		status_new[wb_pkg::status_ie_bit] = c.cp0_wdata[wb_pkg::status_ie_bit];
		status_new[wb_pkg::status_exl_bit] = c.cp0_wdata[wb_pkg::status_exl_bit];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count <= '0;
			compare <= '0;
			status <= '0;
			cause <= '0;
			epc <= '0;
		end
		else
		begin
			count <= wr_count ? c.cp0_wdata : count + 1'b1;
			if (wr_compare)
				compare <= c.cp0_wdata;

			if (wr_compare)
				cause[wb_pkg::cause_ip7_bit] <= 1'b0; // acknowledges the timer
			else if (count == compare)
				cause[wb_pkg::cause_ip7_bit] <= 1'b1;

			if (take_exc)
			begin
				epc <= exc_epc;
				status[wb_pkg::status_exl_bit] <= 1'b1;
				cause[6:2] <= wb_pkg::exc_code_int;
			end
			else
			begin
				if (wr_epc)
					epc <= c.cp0_wdata;
				if (wr_status)
					status <= status_new;
			end
		end
	end

	assign int_pending = cause[wb_pkg::cause_ip7_bit] && status[wb_pkg::status_ie_bit]
		&& !status[wb_pkg::status_exl_bit];

	always_comb
	begin
		case (cp0_raddr)
			wb_pkg::cp0_count:
				cp0_rdata = wr_count ? c.cp0_wdata : count;
			wb_pkg::cp0_compare:
				cp0_rdata = wr_compare ? c.cp0_wdata : compare;
			wb_pkg::cp0_status:
				cp0_rdata = wr_status ? status_new : status;
			wb_pkg::cp0_cause:
				cp0_rdata = cause;
			wb_pkg::cp0_epc:
				cp0_rdata = wr_epc ? c.cp0_wdata : epc;
			default:
				cp0_rdata = '0;
		endcase
	end

	// pipe_ctrl must see exl through int_pending before it raises take_exc
	a_no_nested_exc: assert property (
		@(posedge clk) disable iff (reset) take_exc |-> !status[wb_pkg::status_exl_bit]
	) else $error("cp0_regs: exception taken with exl set");

endmodule

`default_nettype wire

//--- mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage (
	input wb_pkg::ex_mem_t in,
	output wb_pkg::mem_wb_t out
);

	logic [7:0] ld_byte;
	logic [15:0] ld_half;

	assign ld_byte = in.rdata[8*in.byte_off +: 8]; // little endian lanes
	assign ld_half = in.byte_off[1] ? in.rdata[31:16] : in.rdata[15:0];

	always_comb
	begin
		out.pc = in.pc;
		out.wreg = in.wreg;
		out.waddr = in.waddr;
		out.whilo = in.whilo;
		out.hi = in.hi;
		out.lo = in.lo;
		out.cp0_we = in.cp0_we;
		out.cp0_addr = in.cp0_addr;
		out.cp0_wdata = in.cp0_wdata;

		case (in.mem_op)
			wb_pkg::lb:
				out.wdata = {{24{ld_byte[7]}}, ld_byte};
			wb_pkg::lbu:
				out.wdata = {24'd0, ld_byte};
			wb_pkg::lh:
				out.wdata = {{16{ld_half[15]}}, ld_half};
			wb_pkg::lhu:
				out.wdata = {16'd0, ld_half};
			wb_pkg::lw:
				out.wdata = in.rdata;
			default:
				out.wdata = in.wdata; // not a load, alu result
		endcase
	end

endmodule

`default_nettype wire

//--- pipe_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module pipe_ctrl (
	input logic mem_wait,
	input logic int_pending, // already gated with ie and exl
	output logic stall_mem,
	output logic stall_wb,
	output logic stall_ex,
	output logic flush,
	output logic take_exc,
	output logic [wb_pkg::data_w-1:0] exc_pc
);

	assign take_exc = int_pending;
	assign flush = int_pending;

	// exception wins over a memory wait so that both registers clear
	assign stall_mem = mem_wait && !int_pending;
	assign stall_wb = 1'b0; // commit never waits
	assign stall_ex = stall_mem;

	assign exc_pc = wb_pkg::exc_vector;

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_wb -f all.f -o tb_wb_sim
then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/tb_wb_sim
then
	echo "simulation failed"
	exit 1
fi

echo "simulation passed"
exit 0

//--- stage_reg.sv
`timescale 1ns/100ps
`default_nettype none

module stage_reg #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic reset,
	input logic stall_self,
	input logic stall_next,
	input logic flush,
	input payload_t d,
	output payload_t q
);

	always_ff @(posedge clk)
	begin
		if (reset || flush)
			q <= '0;
		else if (stall_self && !stall_next)
			q <= '0; // bubble, all write enables low
		else if (!stall_self)
			q <= d;
	end

	// a stall always reaches back to the stage feeding this register
	a_stall_order: assert property (
		@(posedge clk) disable iff (reset) !(stall_next && !stall_self)
	) else $error("stage_reg: downstream stall without upstream stall");

endmodule

`default_nettype wire

//--- tb_wb.sv
`timescale 1ns/100ps
`default_nettype none

module tb_wb;

	localparam int wait_limit = 400; // cycles per wait loop

	logic clk;
	logic reset;
	logic [31:0] ex_pc;
	logic ex_wreg;
	logic [4:0] ex_waddr;
	logic [31:0] ex_wdata;
	wb_pkg::mem_op_t ex_mem_op;
	logic [1:0] ex_byte_off;
	logic [31:0] ex_rdata;
	logic ex_whilo;
	logic [31:0] ex_hi;
	logic [31:0] ex_lo;
	logic ex_cp0_we;
	logic [4:0] ex_cp0_addr;
	logic [31:0] ex_cp0_wdata;
	logic mem_wait;
	logic [4:0] raddr1;
	logic [4:0] raddr2;
	logic [4:0] cp0_raddr;
	logic stall_ex;
	logic flush;
	logic [31:0] exc_pc;
	logic [31:0] rdata1;
	logic [31:0] rdata2;
	logic [31:0] hi;
	logic [31:0] lo;
	logic [31:0] cp0_rdata;

	wb_pkg::ex_mem_t cur; // next instruction from upstream
	wb_pkg::ex_mem_t drv; // instruction now on the ex ports
	logic drv_wait;
	wb_pkg::ex_mem_t m_em;
	wb_pkg::mem_wb_t m_mw;
	logic [31:0] m_gpr [32];
	logic [31:0] m_hi;
	logic [31:0] m_lo;
	logic [31:0] m_count;
	logic [31:0] m_compare;
	logic [31:0] m_status;
	logic [31:0] m_cause;
	logic [31:0] m_epc;
	logic [31:0] lfsr;
	logic [31:0] next_pc;
	logic held; // upstream must keep cur
	logic flush_seen;
	logic [31:0] flush_epc;
	logic cp0_pick_en;
	logic [4:0] cp0_pick;
	logic follow_pending; // raddr1 tracks the pending write
	int cycle_no;
	int error_count;

	wb_top i_wb_top (
		.clk(clk),
		.reset(reset),
		.ex_pc(ex_pc),
		.ex_wreg(ex_wreg),
		.ex_waddr(ex_waddr),
		.ex_wdata(ex_wdata),
		.ex_mem_op(ex_mem_op),
		.ex_byte_off(ex_byte_off),
		.ex_rdata(ex_rdata),
		.ex_whilo(ex_whilo),
		.ex_hi(ex_hi),
		.ex_lo(ex_lo),
		.ex_cp0_we(ex_cp0_we),
		.ex_cp0_addr(ex_cp0_addr),
		.ex_cp0_wdata(ex_cp0_wdata),
		.mem_wait(mem_wait),
		.raddr1(raddr1),
		.raddr2(raddr2),
		.cp0_raddr(cp0_raddr),
		.stall_ex(stall_ex),
		.flush(flush),
		.exc_pc(exc_pc),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.hi(hi),
		.lo(lo),
		.cp0_rdata(cp0_rdata)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	// galois lfsr, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [31:0] load_value(input wb_pkg::mem_op_t op, input logic [1:0] off,
		input logic [31:0] word, input logic [31:0] alu);
		logic [31:0] b;
		logic [31:0] h;
		b = (word >> (8 * off)) & 32'hff;
		h = off[1] ? (word >> 16) : (word & 32'hffff);
		case (op)
			wb_pkg::lb: return b[7] ? (b | 32'hffff_ff00) : b;
			wb_pkg::lbu: return b;
			wb_pkg::lh: return h[15] ? (h | 32'hffff_0000) : h;
			wb_pkg::lhu: return h;
			wb_pkg::lw: return word;
			default: return alu;
		endcase
	endfunction

	function automatic wb_pkg::mem_wb_t merge_load(input wb_pkg::ex_mem_t e);
		wb_pkg::mem_wb_t w;
		w.pc = e.pc;
		w.wreg = e.wreg;
		w.waddr = e.waddr;
		w.wdata = load_value(e.mem_op, e.byte_off, e.rdata, e.wdata);
		w.whilo = e.whilo;
		w.hi = e.hi;
		w.lo = e.lo;
		w.cp0_we = e.cp0_we;
		w.cp0_addr = e.cp0_addr;
		w.cp0_wdata = e.cp0_wdata;
		return w;
	endfunction

	function automatic logic int_expected();
		return m_cause[15] && m_status[0] && !m_status[1];
	endfunction

	function automatic logic [31:0] gpr_expect(input logic [4:0] a);
		if (a == 5'd0)
			return 32'd0;
		if (m_mw.wreg && m_mw.waddr == a)
			return m_mw.wdata; // pending commit
		return m_gpr[a];
	endfunction

	function automatic logic [31:0] cp0_expect(input logic [4:0] a);
		logic wr;
		wr = m_mw.cp0_we && m_mw.cp0_addr == a;
		case (a)
			wb_pkg::cp0_count: return wr ? m_mw.cp0_wdata : m_count;
			wb_pkg::cp0_compare: return wr ? m_mw.cp0_wdata : m_compare;
			wb_pkg::cp0_status: return wr ? (m_mw.cp0_wdata & 32'h3) : m_status;
			wb_pkg::cp0_cause: return m_cause;
			wb_pkg::cp0_epc: return wr ? m_mw.cp0_wdata : m_epc;
			default: return 32'd0;
		endcase
	endfunction

	function automatic wb_pkg::ex_mem_t rand_instr(input logic allow_cp0);
		wb_pkg::ex_mem_t ins;
		logic [31:0] r;
		ins = '0;
		r = rand_bits(6);
		ins.wreg = r[5];
		ins.waddr = r[4:0];
		ins.wdata = rand_bits(32);
		r = rand_bits(5);
		ins.mem_op = (r[2:0] > 3'd5) ? wb_pkg::none : wb_pkg::mem_op_t'(r[2:0]);
		ins.byte_off = r[4:3];
		ins.rdata = rand_bits(32);
		r = rand_bits(2);
		ins.whilo = (r[1:0] == 2'd0);
		ins.hi = rand_bits(32);
		ins.lo = rand_bits(32);
		if (allow_cp0)
		begin
			r = rand_bits(10);
			ins.cp0_we = (r[1:0] == 2'd0);
			case (r[4:2])
				3'd0: ins.cp0_addr = wb_pkg::cp0_count;
				3'd1: ins.cp0_addr = wb_pkg::cp0_compare;
				3'd2: ins.cp0_addr = wb_pkg::cp0_status;
				3'd3: ins.cp0_addr = wb_pkg::cp0_cause;
				3'd4: ins.cp0_addr = wb_pkg::cp0_epc;
				default: ins.cp0_addr = r[9:5];
			endcase
			ins.cp0_wdata = rand_bits(32);
			if (ins.cp0_addr == wb_pkg::cp0_status)
				ins.cp0_wdata[0] = 1'b0; // timer stays masked here
		end
		return ins;
	endfunction

	task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] got);
		if (exp !== got)
		begin
			error_count++;
			$display("ERROR: %0t ns: %s expected %h got %h", $time, what, exp, got);
			$display("RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timeout: %s did not happen in time", what);
		$display("RESULT: FAIL");
		$fatal(1, "wait timed out");
	endtask

	task automatic apply_ports();
		ex_pc = drv.pc;
		ex_wreg = drv.wreg;
		ex_waddr = drv.waddr;
		ex_wdata = drv.wdata;
		ex_mem_op = drv.mem_op;
		ex_byte_off = drv.byte_off;
		ex_rdata = drv.rdata;
		ex_whilo = drv.whilo;
		ex_hi = drv.hi;
		ex_lo = drv.lo;
		ex_cp0_we = drv.cp0_we;
		ex_cp0_addr = drv.cp0_addr;
		ex_cp0_wdata = drv.cp0_wdata;
		mem_wait = drv_wait;
	endtask

	task automatic model_clear();
		m_em = '0;
		m_mw = '0;
		for (int i = 0; i < 32; i++)
			m_gpr[i] = 32'd0;
		m_hi = 32'd0;
		m_lo = 32'd0;
		m_count = 32'd0;
		m_compare = 32'd0;
		m_status = 32'd0;
		m_cause = 32'd0;
		m_epc = 32'd0;
	endtask

	// state change at one rising edge
	task automatic model_edge();
		logic int_p;
		logic wr_count;
		logic wr_compare;
		int_p = int_expected();
		wr_count = m_mw.cp0_we && m_mw.cp0_addr == wb_pkg::cp0_count;
		wr_compare = m_mw.cp0_we && m_mw.cp0_addr == wb_pkg::cp0_compare;
		if (m_mw.wreg && m_mw.waddr != 5'd0)
			m_gpr[m_mw.waddr] = m_mw.wdata;
		if (m_mw.whilo)
		begin
			m_hi = m_mw.hi;
			m_lo = m_mw.lo;
		end
		if (wr_compare)
			m_cause[15] = 1'b0;
		else if (m_count == m_compare)
			m_cause[15] = 1'b1; // timer match
		m_count = wr_count ? m_mw.cp0_wdata : m_count + 1;
		if (wr_compare)
			m_compare = m_mw.cp0_wdata;
		if (int_p)
		begin
			m_epc = m_em.pc;
			m_status[1] = 1'b1;
			m_cause[6:2] = 5'd0;
		end
		else if (m_mw.cp0_we && m_mw.cp0_addr == wb_pkg::cp0_epc)
			m_epc = m_mw.cp0_wdata;
		else if (m_mw.cp0_we && m_mw.cp0_addr == wb_pkg::cp0_status)
			m_status = m_mw.cp0_wdata & 32'h3;
		if (int_p)
		begin
			m_em = '0;
			m_mw = '0;
		end
		else if (drv_wait)
			m_mw = '0; // bubble, ex/mem holds
		else
		begin
			m_mw = merge_load(m_em);
			m_em = drv;
		end
	endtask

	task automatic run_cycle(input logic wait_in);
		logic [31:0] r;
		logic int_p;
		@(posedge clk);
		model_edge();
		cycle_no++;
		#1;
		drv = cur;
		drv_wait = wait_in;
		apply_ports();
		r = rand_bits(6);
		raddr1 = (r[5] || follow_pending) ? m_mw.waddr : r[4:0];
		raddr2 = cycle_no[4:0]; // walks all registers
		r = rand_bits(8);
		case (r[2:0])
			3'd0: cp0_raddr = wb_pkg::cp0_count;
			3'd1: cp0_raddr = wb_pkg::cp0_compare;
			3'd2: cp0_raddr = wb_pkg::cp0_status;
			3'd3: cp0_raddr = wb_pkg::cp0_cause;
			3'd4: cp0_raddr = wb_pkg::cp0_epc;
			3'd5: cp0_raddr = m_mw.cp0_addr;
			default: cp0_raddr = r[7:3];
		endcase
		if (cp0_pick_en)
			cp0_raddr = cp0_pick;
		#4;
		int_p = int_expected();
		check_eq("stall_ex", 32'(drv_wait && !int_p), 32'(stall_ex));
		check_eq("flush", 32'(int_p), 32'(flush));
		if (int_p)
			check_eq("exc_pc", 32'h0000_0180, exc_pc);
		check_eq($sformatf("rdata1 of r%0d", raddr1), gpr_expect(raddr1), rdata1);
		check_eq($sformatf("rdata2 of r%0d", raddr2), gpr_expect(raddr2), rdata2);
		check_eq("hi", m_mw.whilo ? m_mw.hi : m_hi, hi);
		check_eq("lo", m_mw.whilo ? m_mw.lo : m_lo, lo);
		check_eq($sformatf("cp0 reg %0d", cp0_raddr), cp0_expect(cp0_raddr), cp0_rdata);
		held = drv_wait && !int_p;
		if (int_p)
		begin
			flush_seen = 1'b1;
			flush_epc = m_em.pc;
			next_pc = 32'h0000_0180; // upstream refetches at the vector
		end
	endtask

	task automatic issue(input wb_pkg::ex_mem_t ins, input logic use_wait);
		int start;
		start = cycle_no;
		while (held)
		begin
			if (cycle_no - start > wait_limit)
				stop_on_timeout("release of the stalled instruction");
			run_cycle(use_wait && rand_bits(2) == 0);
		end
		cur = ins;
		cur.pc = next_pc;
		next_pc = next_pc + 4;
		run_cycle(use_wait && rand_bits(2) == 0);
	endtask

	task automatic arm_timer(input int delay);
		wb_pkg::ex_mem_t ins;
		repeat (3)
			issue('0, 1'b0); // earlier count writes land first
		ins = '0;
		ins.cp0_we = 1'b1;
		ins.cp0_addr = wb_pkg::cp0_compare;
		ins.cp0_wdata = m_count + delay;
		issue(ins, 1'b0);
		ins.cp0_addr = wb_pkg::cp0_status;
		ins.cp0_wdata = 32'h1; // ie set, exl cleared
		issue(ins, 1'b0);
	endtask

	task automatic wait_flush();
		int start;
		start = cycle_no;
		flush_seen = 1'b0;
		while (!flush_seen)
		begin
			if (cycle_no - start > wait_limit)
				stop_on_timeout("flush from the timer interrupt");
			issue(rand_instr(1'b0), 1'b1);
		end
	endtask

	task automatic check_interrupt();
		cp0_pick_en = 1'b1;
		cp0_pick = wb_pkg::cp0_epc;
		issue('0, 1'b0);
		check_eq("epc after interrupt", flush_epc, cp0_rdata);
		cp0_pick = wb_pkg::cp0_status;
		issue('0, 1'b0);
		check_eq("status after interrupt", 32'h3, cp0_rdata);
		cp0_pick = wb_pkg::cp0_cause;
		issue('0, 1'b0);
		check_eq("exception code", 32'h0, {27'd0, cp0_rdata[6:2]});
		cp0_pick_en = 1'b0;
		repeat (32)
			issue('0, 1'b0); // sweep shows no flushed write landed
	endtask

	initial
	begin
		wb_pkg::ex_mem_t ins;
		lfsr = 32'd68;
		reset = 1'b1;
		cur = '0;
		drv = '0;
		drv_wait = 1'b0;
		apply_ports();
		raddr1 = 5'd0;
		raddr2 = 5'd0;
		cp0_raddr = 5'd0;
		model_clear();
		held = 1'b0;
		flush_seen = 1'b0;
		flush_epc = 32'd0;
		cp0_pick_en = 1'b0;
		cp0_pick = 5'd0;
		follow_pending = 1'b0;
		cycle_no = 0;
		error_count = 0;
		next_pc = 32'h0000_1000;
		repeat (5)
			@(posedge clk);
		#1;
		reset = 1'b0;
		raddr1 = 5'd1;
		raddr2 = 5'd31;
		cp0_raddr = wb_pkg::cp0_status;
		#4;
		check_eq("stall_ex after reset", 32'd0, 32'(stall_ex));
		check_eq("flush after reset", 32'd0, 32'(flush));
		check_eq("rdata1 after reset", 32'd0, rdata1);
		check_eq("rdata2 after reset", 32'd0, rdata2);
		check_eq("hi after reset", 32'd0, hi);
		check_eq("lo after reset", 32'd0, lo);
		check_eq("status after reset", 32'd0, cp0_rdata);
		repeat (32)
			issue('0, 1'b0);

		// every load kind at every byte offset
		follow_pending = 1'b1;
		for (int op = 1; op <= 5; op++)
			for (int off = 0; off < 4; off++)
			begin
				ins = rand_instr(1'b0);
				ins.wreg = 1'b1;
				if (ins.waddr == 5'd0)
					ins.waddr = 5'd1; // r0 would hide the result
				ins.mem_op = wb_pkg::mem_op_t'(op);
				ins.byte_off = off[1:0];
				issue(ins, 1'b0);
			end
		repeat (2)
			issue('0, 1'b0);
		follow_pending = 1'b0;

		repeat (400)
			issue(rand_instr(1'b1), 1'b1);

		arm_timer(40);
		wait_flush();
		check_interrupt();
		arm_timer(40); // clearing exl must let the timer in again
		wait_flush();
		check_interrupt();

		repeat (100)
			issue(rand_instr(1'b0), 1'b1);

		if (error_count == 0)
		begin
			$display("RESULT: PASS");
			$finish;
		end
		else
		begin
			$display("RESULT: FAIL");
			$fatal(1, "checks failed");
		end
	end

endmodule

`default_nettype wire

//--- wb_pkg.sv
`default_nettype none

package wb_pkg;

	localparam int data_w = 32;
	localparam int reg_addr_w = 5;

	typedef enum logic [2:0] {
		none,
		lb,
		lbu,
		lh,
		lhu,
		lw
	} mem_op_t;

	localparam logic [reg_addr_w-1:0] cp0_count = 5'd9;
	localparam logic [reg_addr_w-1:0] cp0_compare = 5'd11;
	localparam logic [reg_addr_w-1:0] cp0_status = 5'd12;
	localparam logic [reg_addr_w-1:0] cp0_cause = 5'd13;
	localparam logic [reg_addr_w-1:0] cp0_epc = 5'd14;

	localparam int status_ie_bit = 0;
	localparam int status_exl_bit = 1;
	localparam int cause_ip7_bit = 15;

	localparam logic [4:0] exc_code_int = 5'd0;
	localparam logic [data_w-1:0] exc_vector = 32'h0000_0180;

	typedef struct packed {
		logic [data_w-1:0] pc;
		logic wreg;
		logic [reg_addr_w-1:0] waddr;
		logic [data_w-1:0] wdata;
		mem_op_t mem_op;
		logic [1:0] byte_off; // low address bits of the load
		logic [data_w-1:0] rdata; // word as read from memory
		logic whilo;
		logic [data_w-1:0] hi;
		logic [data_w-1:0] lo;
		logic cp0_we;
		logic [reg_addr_w-1:0] cp0_addr;
		logic [data_w-1:0] cp0_wdata;
	} ex_mem_t;

	typedef struct packed {
		logic [data_w-1:0] pc;
		logic wreg;
		logic [reg_addr_w-1:0] waddr;
		logic [data_w-1:0] wdata; // load already merged
		logic whilo;
		logic [data_w-1:0] hi;
		logic [data_w-1:0] lo;
		logic cp0_we;
		logic [reg_addr_w-1:0] cp0_addr;
		logic [data_w-1:0] cp0_wdata;
	} mem_wb_t;

endpackage

`default_nettype wire

//--- wb_top.sv
`timescale 1ns/100ps
`default_nettype none

module wb_top (
	input logic clk,
	input logic reset,
	input logic [wb_pkg::data_w-1:0] ex_pc,
	input logic ex_wreg,
	input logic [wb_pkg::reg_addr_w-1:0] ex_waddr,
	input logic [wb_pkg::data_w-1:0] ex_wdata,
	input wb_pkg::mem_op_t ex_mem_op,
	input logic [1:0] ex_byte_off,
	input logic [wb_pkg::data_w-1:0] ex_rdata,
	input logic ex_whilo,
	input logic [wb_pkg::data_w-1:0] ex_hi,
	input logic [wb_pkg::data_w-1:0] ex_lo,
	input logic ex_cp0_we,
	input logic [wb_pkg::reg_addr_w-1:0] ex_cp0_addr,
	input logic [wb_pkg::data_w-1:0] ex_cp0_wdata,
	input logic mem_wait,
	input logic [wb_pkg::reg_addr_w-1:0] raddr1,
	input logic [wb_pkg::reg_addr_w-1:0] raddr2,
	input logic [wb_pkg::reg_addr_w-1:0] cp0_raddr,
	output logic stall_ex,
	output logic flush,
	output logic [wb_pkg::data_w-1:0] exc_pc,
	output logic [wb_pkg::data_w-1:0] rdata1,
	output logic [wb_pkg::data_w-1:0] rdata2,
	output logic [wb_pkg::data_w-1:0] hi,
	output logic [wb_pkg::data_w-1:0] lo,
	output logic [wb_pkg::data_w-1:0] cp0_rdata
);

	wb_pkg::ex_mem_t ex_mem_d;
	wb_pkg::ex_mem_t ex_mem_q;
	wb_pkg::mem_wb_t mem_wb_d;
	wb_pkg::mem_wb_t mem_wb_q;
	logic stall_mem;
	logic stall_wb;
	logic take_exc;
	logic int_pending;

	commit_if committed();
	commit_if pending();

	assign ex_mem_d = '{
		pc: ex_pc,
		wreg: ex_wreg,
		waddr: ex_waddr,
		wdata: ex_wdata,
		mem_op: ex_mem_op,
		byte_off: ex_byte_off,
		rdata: ex_rdata,
		whilo: ex_whilo,
		hi: ex_hi,
		lo: ex_lo,
		cp0_we: ex_cp0_we,
		cp0_addr: ex_cp0_addr,
		cp0_wdata: ex_cp0_wdata
	};

	pipe_ctrl i_pipe_ctrl (
		.mem_wait(mem_wait),
		.int_pending(int_pending),
		.stall_mem(stall_mem),
		.stall_wb(stall_wb),
		.stall_ex(stall_ex),
		.flush(flush),
		.take_exc(take_exc),
		.exc_pc(exc_pc)
	);

	stage_reg #(.payload_t(wb_pkg::ex_mem_t)) ex_mem_reg (
		.clk(clk),
		.reset(reset),
		.stall_self(stall_ex),
		.stall_next(stall_mem),
		.flush(flush),
		.d(ex_mem_d),
		.q(ex_mem_q)
	);

	mem_stage i_mem_stage (
		.in(ex_mem_q),
		.out(mem_wb_d)
	);

	// a wait in the memory stage turns into a bubble here
	stage_reg #(.payload_t(wb_pkg::mem_wb_t)) mem_wb_reg (
		.clk(clk),
		.reset(reset),
		.stall_self(stall_mem),
		.stall_next(stall_wb),
		.flush(flush),
		.d(mem_wb_d),
		.q(mem_wb_q)
	);

	assign committed.pc = mem_wb_q.pc;
	assign committed.wreg = mem_wb_q.wreg;
	assign committed.waddr = mem_wb_q.waddr;
	assign committed.wdata = mem_wb_q.wdata;
	assign committed.whilo = mem_wb_q.whilo;
	assign committed.hi = mem_wb_q.hi;
	assign committed.lo = mem_wb_q.lo;
	assign committed.cp0_we = mem_wb_q.cp0_we;
	assign committed.cp0_addr = mem_wb_q.cp0_addr;
	assign committed.cp0_wdata = mem_wb_q.cp0_wdata;

	assign pending.pc = mem_wb_q.pc;
	assign pending.wreg = mem_wb_q.wreg;
	assign pending.waddr = mem_wb_q.waddr;
	assign pending.wdata = mem_wb_q.wdata;
	assign pending.whilo = mem_wb_q.whilo;
	assign pending.hi = mem_wb_q.hi;
	assign pending.lo = mem_wb_q.lo;
	assign pending.cp0_we = mem_wb_q.cp0_we;
	assign pending.cp0_addr = mem_wb_q.cp0_addr;
	assign pending.cp0_wdata = mem_wb_q.cp0_wdata;

	arch_regs i_arch_regs (
		.clk(clk),
		.reset(reset),
		.c(committed.regs),
		.raddr1(raddr1),
		.raddr2(raddr2),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.hi(hi),
		.lo(lo),
		.pend(pending.regs)
	);

	cp0_regs i_cp0_regs (
		.clk(clk),
		.reset(reset),
		.take_exc(take_exc),
		.c(committed.cp0),
		.exc_epc(ex_mem_q.pc), // instruction lost to the flush
		.cp0_raddr(cp0_raddr),
		.cp0_rdata(cp0_rdata),
		.int_pending(int_pending)
	);

endmodule

`default_nettype wire
